//--- verilog/imu_params.svh
//////////////////////////////////////////////////
// IMU front end constants
// Sensor addresses, bit timing and table sizes
//////////////////////////////////////////////////
`ifndef IMU_PARAMS_SVH
`define IMU_PARAMS_SVH

// 7-bit I2C device addresses
`define IMU_ACCEL_ADDR 7'h53
`define IMU_GYRO_ADDR 7'h68

// CLOCK_50 cycles per quarter bit, 50 MHz / (4 * 31) is about 400 kHz SCL
`define IMU_QUARTER_DIV 31

// Start-up wait before the init writes, in quarter ticks
`define IMU_STARTUP_QUARTERS 200

// Gap between read frames, in quarter ticks
`define IMU_IDLE_QUARTERS 100

// Init table length
`define IMU_INIT_COUNT 9

// Single-byte reads per frame, six per sensor
`define IMU_READ_COUNT 12

`endif

//--- verilog/imuPkg.sv
//////////////////////////////////////////////////
// IMU front end types
// Bus pins, I2C command/response and samples
//////////////////////////////////////////////////
package imuPkg;

`include "imu_params.svh"

    // Open-drain drive-low enables, a line floats high when its bit is 0
    typedef struct packed {
        logic sclLow;
        logic sdaLow;
    } i2cBus_t;

    // One register transaction request
    typedef struct packed {
        logic       isRead;     // 1 for register read
        logic [6:0] devAddr;    // 7-bit slave address
        logic [7:0] regAddr;
        logic [7:0] wrData;     // Ignored on reads
    } i2cCmd_t;

    // Result of one transaction
    typedef struct packed {
        logic [7:0] rdData;
        logic       ackError;   // Some ACK slot saw SDA high
    } i2cRsp_t;

    typedef logic signed [15:0] axisSample_t;

    typedef struct packed {
        axisSample_t accelX;
        axisSample_t accelY;
        axisSample_t accelZ;
        axisSample_t gyroX;
        axisSample_t gyroY;
        axisSample_t gyroZ;
    } imuSample_t;

    // Table indexes for the sequencer
    typedef logic [$clog2(`IMU_INIT_COUNT)-1:0] initIdx_t;
    typedef logic [$clog2(`IMU_READ_COUNT)-1:0] readIdx_t;

endpackage

//--- verilog/i2cBitTimer.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// I2C quarter-bit timer
// One-cycle tick every IMU_QUARTER_DIV clocks
//////////////////////////////////////////////////
`include "imu_params.svh"

module i2cBitTimer (
    input  logic CLOCK_50,
    input  logic reset_n,
    output logic quarterTick
);

    localparam int divWidth = $clog2(`IMU_QUARTER_DIV + 1);

    logic [divWidth-1:0] divCount;

    // Counts 0 .. DIV-1, the tick is registered on the reload
    always_ff @(posedge CLOCK_50)
    begin
        if (!reset_n)
        begin
            divCount    <= '0;
            quarterTick <= 1'b0;
        end
        else if (divCount == divWidth'(`IMU_QUARTER_DIV - 1))
        begin
            divCount    <= '0;
            quarterTick <= 1'b1;
        end
        else
        begin
            divCount    <= divCount + 1'b1;
            quarterTick <= 1'b0;
        end
    end

endmodule

//--- verilog/i2cMaster.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// I2C master, one register write or read
// Bits are four quarters: SDA set, SCL up, sample, SCL down
//////////////////////////////////////////////////
module i2cMaster (
    input  logic            CLOCK_50,
    input  logic            reset_n,
    input  logic            quarterTick,
    input  imuPkg::i2cCmd_t cmd,
    input  logic            cmdValid,
    output logic            cmdReady,
    output imuPkg::i2cRsp_t rsp,
    output logic            rspValid,
    output imuPkg::i2cBus_t bus,
    input  logic            sdaIn
);
    import imuPkg::*;

    typedef enum logic [1:0] {phIdle, phStart, phByte, phStop} phase_t;
    typedef enum logic [2:0] {selAddrW, selReg, selData, selAddrR, selRead} byteSel_t;

    localparam logic [3:0] ackBit = 4'd8;   // Ninth clock of a byte

    phase_t     phase;
    byteSel_t   byteSel;        // Which byte of the transaction is on the wire
    logic [1:0] quarter;
    logic [3:0] bitCount;
    logic [7:0] shiftReg;
    logic       ackErr;
    i2cCmd_t    cmdReg;
    logic       dataLow;

    assign cmdReady = (phase == phIdle);

    // SDA for the coming bit
    always_comb
    begin
        if (bitCount == ackBit || byteSel == selRead)
            dataLow = 1'b0;             // Slave ACK, read data or our NACK
        else
            dataLow = ~shiftReg[7];     // MSB first
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (!reset_n)
        begin
            phase    <= phIdle;
            byteSel  <= selAddrW;
            quarter  <= '0;
            bitCount <= '0;
            ackErr   <= 1'b0;
            rspValid <= 1'b0;
            bus      <= '0;             // Both lines released
        end
        else
        begin
            rspValid <= 1'b0;
            if (phase == phIdle)
            begin
                if (cmdValid)
                begin
                    cmdReg  <= cmd;
                    phase   <= phStart;
                    byteSel <= selAddrW;
                    quarter <= '0;
                    ackErr  <= 1'b0;
                end
            end
            else if (quarterTick)
            begin
                quarter <= quarter + 1'b1;
                case (phase)
                    // Also serves as repeated START, SCL is low on entry then
                    phStart:
                        case (quarter)
                            2'd0: bus.sdaLow <= 1'b0;
                            2'd1: bus.sclLow <= 1'b0;
                            2'd2: bus.sdaLow <= 1'b1;   // SDA falls with SCL high
                            default:
                            begin
                                bus.sclLow <= 1'b1;
                                phase      <= phByte;
                                bitCount   <= '0;
                                shiftReg   <= {cmdReg.devAddr, byteSel == selAddrR};
                            end
                        endcase

                    phByte:
                        case (quarter)
                            2'd0: bus.sdaLow <= dataLow;    // Only while SCL low
                            2'd1: bus.sclLow <= 1'b0;
                            2'd2:
                            begin
                                if (bitCount != ackBit)
                                    shiftReg <= {shiftReg[6:0], sdaIn};
                                else if (byteSel != selRead && sdaIn)
                                    ackErr <= 1'b1;     // No ACK, keep going to STOP
                            end
                            default:
                            begin
                                bus.sclLow <= 1'b1;
                                if (bitCount != ackBit)
                                    bitCount <= bitCount + 1'b1;
                                else
                                begin
                                    bitCount <= '0;
                                    case (byteSel)
                                        selAddrW:
                                        begin
                                            byteSel  <= selReg;
                                            shiftReg <= cmdReg.regAddr;
                                        end
                                        selReg:
                                            if (cmdReg.isRead)
                                            begin
                                                byteSel <= selAddrR;
                                                phase   <= phStart;
                                            end
                                            else
                                            begin
                                                byteSel  <= selData;
                                                shiftReg <= cmdReg.wrData;
                                            end
                                        selAddrR: byteSel <= selRead;
                                        default: phase <= phStop;
                                    endcase
                                end
                            end
                        endcase

                    phStop:
                        case (quarter)
                            2'd0: bus.sdaLow <= 1'b1;
                            2'd1: bus.sclLow <= 1'b0;
                            2'd2: bus.sdaLow <= 1'b0;   // SDA rises with SCL high
                            default:
                            begin
                                phase    <= phIdle;
                                rspValid <= 1'b1;
                                rsp      <= '{rdData: shiftReg, ackError: ackErr};
                            end
                        endcase

                    default: phase <= phIdle;
                endcase
            end
        end
    end

endmodule

//--- verilog/imuSequencer.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// IMU sequencer
// Start-up wait, init writes, then read frames
//////////////////////////////////////////////////
`include "imu_params.svh"

module imuSequencer (
    input  logic               CLOCK_50,
    input  logic               reset_n,
    output imuPkg::i2cCmd_t    cmd,
    output logic               cmdValid,
    input  logic               cmdReady,
    input  imuPkg::i2cRsp_t    rsp,
    input  logic               rspValid,
    input  logic               quarterTick,
    output imuPkg::imuSample_t sample,
    output logic               sampleValid,
    output logic               busError
);
    import imuPkg::*;

    typedef enum logic [2:0] {stWait, stInit, stRead, stPublish, stGap} seqState_t;

    localparam int accelReads = `IMU_READ_COUNT / 2;
    localparam int waitMax = (`IMU_STARTUP_QUARTERS > `IMU_IDLE_QUARTERS)
                           ? `IMU_STARTUP_QUARTERS : `IMU_IDLE_QUARTERS;
    localparam int waitWidth = $clog2(waitMax + 1);

    seqState_t            state;
    logic [waitWidth-1:0] waitCount;
    logic [waitWidth-1:0] waitLimit;
    initIdx_t             initIdx;
    readIdx_t             readIdx;
    logic                 pending;      // Command accepted, response not yet back
    logic                 frameErr;
    logic [2:0]           axisSel;
    logic                 highByte;
    axisSample_t          axisBuf [6];  // accelX .. gyroZ

    // Entries are {isRead, devAddr, regAddr, wrData}
    function automatic i2cCmd_t initEntry(initIdx_t idx);
        i2cCmd_t entry;
        case (idx)
            4'd0: entry = '{1'b0, `IMU_ACCEL_ADDR, 8'h2D, 8'h00};   // Standby
            4'd1: entry = '{1'b0, `IMU_ACCEL_ADDR, 8'h2D, 8'h16};
            4'd2: entry = '{1'b0, `IMU_ACCEL_ADDR, 8'h2D, 8'h08};   // Measure
            4'd3: entry = '{1'b0, `IMU_ACCEL_ADDR, 8'h31, 8'h08};   // Full res
            4'd4: entry = '{1'b0, `IMU_ACCEL_ADDR, 8'h2C, 8'h08};
            4'd5: entry = '{1'b0, `IMU_GYRO_ADDR, 8'h3E, 8'h00};    // Power mgmt
            4'd6: entry = '{1'b0, `IMU_GYRO_ADDR, 8'h15, 8'hFF};
            4'd7: entry = '{1'b0, `IMU_GYRO_ADDR, 8'h16, 8'h1E};
            default: entry = '{1'b0, `IMU_GYRO_ADDR, 8'h17, 8'h00};
        endcase
        return entry;
    endfunction

    // Accel 0x32..0x37, gyro 0x1D..0x22
    function automatic i2cCmd_t readEntry(readIdx_t idx);
        i2cCmd_t entry;
        entry.isRead = 1'b1;
        entry.wrData = 8'h00;
        if (idx < readIdx_t'(accelReads))
        begin
            entry.devAddr = `IMU_ACCEL_ADDR;
            entry.regAddr = 8'h32 + 8'(idx);
        end
        else
        begin
            entry.devAddr = `IMU_GYRO_ADDR;
            entry.regAddr = 8'h17 + 8'(idx);    // 0x1D at idx 6
        end
        return entry;
    endfunction

    assign cmd = (state == stInit) ? initEntry(initIdx) : readEntry(readIdx);
    assign waitLimit = (state == stWait) ? waitWidth'(`IMU_STARTUP_QUARTERS - 1)
                                         : waitWidth'(`IMU_IDLE_QUARTERS - 1);

    // Accel is low byte first, gyro high byte first
    assign axisSel  = 3'(readIdx >> 1);
    assign highByte = (readIdx < readIdx_t'(accelReads)) ? readIdx[0] : ~readIdx[0];

    always_ff @(posedge CLOCK_50)
    begin
        if (!reset_n)
        begin
            state       <= stWait;
            waitCount   <= '0;
            initIdx     <= '0;
            readIdx     <= '0;
            pending     <= 1'b0;
            frameErr    <= 1'b0;
            cmdValid    <= 1'b0;
            sampleValid <= 1'b0;
            busError    <= 1'b0;
        end
        else
        begin
            sampleValid <= 1'b0;
            if (cmdValid && cmdReady)
            begin
                cmdValid <= 1'b0;
                pending  <= 1'b1;
            end
            if (rspValid && rsp.ackError)
                busError <= 1'b1;           // Sticky

            case (state)
                stWait, stGap:
                    if (quarterTick)
                    begin
                        if (waitCount == waitLimit)
                        begin
                            waitCount <= '0;
                            readIdx   <= '0;
                            frameErr  <= 1'b0;
                            state     <= (state == stWait) ? stInit : stRead;
                        end
                        else
                            waitCount <= waitCount + 1'b1;
                    end

                stInit:
                    if (!pending && !cmdValid)
                        cmdValid <= 1'b1;
                    else if (rspValid)
                    begin
                        pending <= 1'b0;
                        if (initIdx == initIdx_t'(`IMU_INIT_COUNT - 1))
                            state <= stRead;    // readIdx and frameErr are clear here
                        else
                            initIdx <= initIdx + 1'b1;
                    end

                stRead:
                    if (!pending && !cmdValid)
                        cmdValid <= 1'b1;
                    else if (rspValid)
                    begin
                        pending <= 1'b0;
                        if (rsp.ackError)
                            frameErr <= 1'b1;
                        if (highByte)
                            axisBuf[axisSel][15:8] <= rsp.rdData;
                        else
                            axisBuf[axisSel][7:0] <= rsp.rdData;
                        if (readIdx == readIdx_t'(`IMU_READ_COUNT - 1))
                            state <= stPublish;
                        else
                            readIdx <= readIdx + 1'b1;
                    end

                // One cycle later so the last byte is in axisBuf
                stPublish:
                begin
                    if (!frameErr)
                    begin
                        sampleValid   <= 1'b1;
                        sample.accelX <= axisBuf[0];
                        sample.accelY <= axisBuf[1];
                        sample.accelZ <= axisBuf[2];
                        sample.gyroX  <= axisBuf[3];
                        sample.gyroY  <= axisBuf[4];
                        sample.gyroZ  <= axisBuf[5];
                    end
                    waitCount <= '0;
                    state     <= stGap;
                end

                default: state <= stWait;
            endcase
        end
    end

endmodule

//--- verilog/imuInterface.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// IMU interface top level
// Bit timer, I2C master and sequencer
//////////////////////////////////////////////////
module imuInterface (
    input  logic               CLOCK_50,
    input  logic               reset_n,
    output imuPkg::i2cBus_t    i2cBus,
    input  logic               sdaIn,
    output imuPkg::imuSample_t sample,
    output logic               sampleValid,
    output logic               busError
);
    import imuPkg::*;

    logic    quarterTick;
    i2cCmd_t cmd;
    logic    cmdValid;
    logic    cmdReady;
    i2cRsp_t rsp;
    logic    rspValid;

    i2cBitTimer timer_i (
        .CLOCK_50    (CLOCK_50),
        .reset_n     (reset_n),
        .quarterTick (quarterTick)
    );

    i2cMaster master_i (
        .CLOCK_50    (CLOCK_50),
        .reset_n     (reset_n),
        .quarterTick (quarterTick),
        .cmd         (cmd),
        .cmdValid    (cmdValid),
        .cmdReady    (cmdReady),
        .rsp         (rsp),
        .rspValid    (rspValid),
        .bus         (i2cBus),
        .sdaIn       (sdaIn)        // Resolved SDA level from the pad
    );

    imuSequencer sequencer_i (
        .CLOCK_50    (CLOCK_50),
        .reset_n     (reset_n),
        .cmd         (cmd),
        .cmdValid    (cmdValid),
        .cmdReady    (cmdReady),
        .rsp         (rsp),
        .rspValid    (rspValid),
        .quarterTick (quarterTick),
        .sample      (sample),
        .sampleValid (sampleValid),
        .busError    (busError)
    );

endmodule

//--- tb/i2cSensorModel.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// I2C sensor model for accelerometer and gyroscope
// Register files, write log, NACK option, protocol checks
//////////////////////////////////////////////////
`include "imu_params.svh"

module i2cSensorModel (
    input  logic CLOCK_50,
    input  logic reset_n,
    input  logic sclLine,
    input  logic sdaLine,
    input  logic nackGyro,
    output logic sdaLow,
    output logic protoErr
);

    logic [7:0] accelRegs [256];
    logic [7:0] gyroRegs [256];
    logic [6:0] writeDev [16];      // Write log in bus order
    logic [7:0] writeReg [16];
    logic [7:0] writeData [16];
    int         writeCount;
    int         readCount;
    int         writesAtFirstRead;

    logic       prevScl;
    logic       prevSda;
    logic       active;
    logic       isRead;
    logic       isGyro;
    logic       addressed;
    logic       txMode;             // Model drives a data byte
    logic       readDone;
    logic       startHold;          // SCL has not fallen since the START
    logic [3:0] bitCnt;
    logic [1:0] byteIdx;
    logic [7:0] shiftIn;
    logic [7:0] txByte;
    logic [7:0] regPtr;
    logic [7:0] rdByte;

    assign rdByte = isGyro ? gyroRegs[regPtr] : accelRegs[regPtr];

    task automatic setReg(input logic gyro, input logic [7:0] addr, input logic [7:0] data);
        if (gyro)
            gyroRegs[addr] = data;
        else
            accelRegs[addr] = data;
    endtask

    task automatic flag(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        protoErr <= 1'b1;
    endtask

    always @(posedge CLOCK_50)
    begin
        if (!reset_n)
        begin
            prevScl           <= 1'b1;
            prevSda           <= 1'b1;
            active            <= 1'b0;
            sdaLow            <= 1'b0;
            protoErr          <= 1'b0;
            txMode            <= 1'b0;
            readDone          <= 1'b0;
            startHold         <= 1'b0;
            bitCnt            <= '0;
            writeCount        <= 0;
            readCount         <= 0;
            writesAtFirstRead <= -1;
        end
        else
        begin
            prevScl <= sclLine;
            prevSda <= sdaLine;
            if (prevScl && sclLine && prevSda != sdaLine)
            begin
                // SDA moved with SCL high so only START or STOP is legal
                assert (!active || bitCnt == 0)
                else flag("SDA changed while SCL high inside a byte");
                sdaLow <= 1'b0;
                if (!sdaLine)
                begin
                    assert (!readDone)
                    else flag("read NACK followed by a repeated START instead of STOP");
                    active    <= 1'b1;      // START or repeated START
                    startHold <= 1'b1;
                    bitCnt    <= '0;
                    byteIdx   <= '0;
                    txMode    <= 1'b0;
                end
                else
                begin
                    active   <= 1'b0;
                    readDone <= 1'b0;
                end
            end
            else if (active && !prevScl && sclLine)
            begin
                if (bitCnt != 4'd8)
                    shiftIn <= {shiftIn[6:0], sdaLine};
                else if (txMode)
                begin
                    assert (sdaLine) else flag("master ACKed a single-byte read");
                    readDone <= 1'b1;
                end
            end
            else if (active && prevScl && !sclLine)
            begin
                if (startHold)
                    startHold <= 1'b0;          // End of the START, no data bit yet
                else if (bitCnt == 4'd8)        // ACK slot over
                begin
                    bitCnt  <= '0;
                    byteIdx <= byteIdx + 1'b1;
                    sdaLow  <= 1'b0;
                    txMode  <= 1'b0;
                    if (isRead && addressed && byteIdx == 2'd0)
                    begin
                        txMode    <= 1'b1;
                        txByte    <= rdByte;
                        sdaLow    <= ~rdByte[7];
                        readCount <= readCount + 1;
                        if (readCount == 0)
                            writesAtFirstRead <= writeCount;
                    end
                end
                else if (bitCnt == 4'd7)        // Byte complete and the ACK slot follows
                begin
                    bitCnt <= 4'd8;
                    if (txMode)
                        sdaLow <= 1'b0;         // Leave the slot to the master
                    else if (byteIdx == 2'd0)
                    begin
                        isRead    <= shiftIn[0];
                        isGyro    <= shiftIn[7:1] == `IMU_GYRO_ADDR;
                        addressed <= shiftIn[7:1] == `IMU_ACCEL_ADDR
                                  || (shiftIn[7:1] == `IMU_GYRO_ADDR && !nackGyro);
                        sdaLow    <= shiftIn[7:1] == `IMU_ACCEL_ADDR
                                  || (shiftIn[7:1] == `IMU_GYRO_ADDR && !nackGyro);
                    end
                    else
                    begin
                        sdaLow <= addressed;
                        if (addressed && byteIdx == 2'd1)
                            regPtr <= shiftIn;
                        if (addressed && byteIdx == 2'd2 && writeCount < 16)
                        begin
                            writeDev[writeCount]  <= isGyro ? `IMU_GYRO_ADDR : `IMU_ACCEL_ADDR;
                            writeReg[writeCount]  <= regPtr;
                            writeData[writeCount] <= shiftIn;
                            writeCount            <= writeCount + 1;
                        end
                    end
                end
                else
                begin
                    bitCnt <= bitCnt + 1'b1;
                    if (txMode)
                        sdaLow <= ~txByte[3'(6 - bitCnt)];   // MSB first
                end
            end
        end
    end

endmodule

//--- tb/imuInterfaceTb.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// IMU interface testbench
// Init table, sample assembly, data refresh, NACK run
//////////////////////////////////////////////////
`include "imu_params.svh"

module imuInterfaceTb;
    import imuPkg::*;

    // Upper bounds per transaction in quarter ticks
    localparam int writeQuarters = 120;
    localparam int readQuarters  = 160;
    localparam int frameQuarters = `IMU_READ_COUNT * readQuarters + `IMU_IDLE_QUARTERS;
    localparam int initQuarters  = `IMU_STARTUP_QUARTERS + `IMU_INIT_COUNT * writeQuarters;
    localparam int frameCycles   = frameQuarters * `IMU_QUARTER_DIV;
    localparam int cycleLimit    = 2 * (2 * initQuarters + 5 * frameQuarters) * `IMU_QUARTER_DIV;

    localparam logic [6:0] expDev [9] = '{`IMU_ACCEL_ADDR, `IMU_ACCEL_ADDR, `IMU_ACCEL_ADDR,
        `IMU_ACCEL_ADDR, `IMU_ACCEL_ADDR, `IMU_GYRO_ADDR, `IMU_GYRO_ADDR, `IMU_GYRO_ADDR,
        `IMU_GYRO_ADDR};
    localparam logic [7:0] expReg [9] = '{8'h2D, 8'h2D, 8'h2D, 8'h31, 8'h2C,
        8'h3E, 8'h15, 8'h16, 8'h17};
    localparam logic [7:0] expData [9] = '{8'h00, 8'h16, 8'h08, 8'h08, 8'h08,
        8'h00, 8'hFF, 8'h1E, 8'h00};

    logic       CLOCK_50 = 1'b0;
    logic       reset_n;
    logic       nackGyro;
    i2cBus_t    i2cBus;
    logic       sdaIn;
    logic       sclLine;
    logic       sdaLine;
    logic       modelSdaLow;
    logic       protoErr;
    imuSample_t sample;
    logic       sampleValid;
    logic       busError;
    int         cycleCount = 0;
    logic [7:0] accelShadow [6];    // Registers 0x32..0x37
    logic [7:0] gyroShadow [6];     // Registers 0x1D..0x22

    // Wired-AND open-drain lines
    assign sclLine = ~i2cBus.sclLow;
    assign sdaLine = ~(i2cBus.sdaLow | modelSdaLow);
    assign sdaIn   = sdaLine;

    imuInterface dut_i (
        .CLOCK_50    (CLOCK_50),
        .reset_n     (reset_n),
        .i2cBus      (i2cBus),
        .sdaIn       (sdaIn),
        .sample      (sample),
        .sampleValid (sampleValid),
        .busError    (busError)
    );

    i2cSensorModel model_i (
        .CLOCK_50 (CLOCK_50),
        .reset_n  (reset_n),
        .sclLine  (sclLine),
        .sdaLine  (sdaLine),
        .nackGyro (nackGyro),
        .sdaLow   (modelSdaLow),
        .protoErr (protoErr)
    );

    always #2 CLOCK_50 = ~CLOCK_50;

    task automatic stopOnFailure();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic reportFailure(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        stopOnFailure();
    endtask

    always @(posedge CLOCK_50)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            stopOnFailure();
        end
    end

    always @(negedge CLOCK_50)
        if (protoErr)
            stopOnFailure();    // Bus protocol error seen by the model

    task automatic applyReset(input logic nack);
        @(posedge CLOCK_50);
        reset_n  <= 1'b0;
        nackGyro <= nack;
        repeat (2) @(posedge CLOCK_50);
        reset_n <= 1'b1;
    endtask

    task automatic loadSensorData();
        for (int i = 0; i < 6; i++)
        begin
            accelShadow[i] = 8'($urandom);
            gyroShadow[i]  = 8'($urandom);
            model_i.setReg(1'b0, 8'h32 + 8'(i), accelShadow[i]);
            model_i.setReg(1'b1, 8'h1D + 8'(i), gyroShadow[i]);
        end
    endtask

    // Accel pairs are low byte first and gyro pairs high byte first
    function automatic axisSample_t expectedAxis(input int axis);
        if (axis < 3)
            return {accelShadow[2 * axis + 1], accelShadow[2 * axis]};
        else
            return {gyroShadow[2 * (axis - 3)], gyroShadow[2 * (axis - 3) + 1]};
    endfunction

    function automatic axisSample_t sampleAxis(input imuSample_t s, input int axis);
        case (axis)
            0: return s.accelX;
            1: return s.accelY;
            2: return s.accelZ;
            3: return s.gyroX;
            4: return s.gyroY;
            default: return s.gyroZ;
        endcase
    endfunction

    task automatic waitSampleValid();
        do
            @(negedge CLOCK_50);
        while (!sampleValid);
    endtask

    task automatic checkSample(input int frame);
        for (int a = 0; a < 6; a++)
            assert (sampleAxis(sample, a) == expectedAxis(a))
            else reportFailure($sformatf("frame %0d axis %0d is %h, expected %h",
                                         frame, a, sampleAxis(sample, a), expectedAxis(a)));
    endtask

    task automatic checkInitWrites();
        assert (model_i.writeCount == `IMU_INIT_COUNT)
        else reportFailure($sformatf("%0d writes logged", model_i.writeCount));
        assert (model_i.writesAtFirstRead == `IMU_INIT_COUNT)
        else reportFailure("a read came before the end of the init writes");
        for (int i = 0; i < `IMU_INIT_COUNT; i++)
            assert (model_i.writeDev[i] == expDev[i] && model_i.writeReg[i] == expReg[i]
                    && model_i.writeData[i] == expData[i])
            else reportFailure($sformatf("init write %0d was dev %h reg %h data %h", i,
                               model_i.writeDev[i], model_i.writeReg[i], model_i.writeData[i]));
    endtask

    initial
    begin
        reset_n  = 1'b0;
        nackGyro = 1'b0;
        void'($urandom(32'h029e_3729));
        loadSensorData();
        applyReset(1'b0);

        // Quiet bus during the start-up wait
        repeat (`IMU_STARTUP_QUARTERS * `IMU_QUARTER_DIV / 2) @(negedge CLOCK_50)
            assert (i2cBus == '0 && !sampleValid && !busError)
            else reportFailure("outputs active during the start-up wait");

        waitSampleValid();
        checkInitWrites();
        checkSample(1);
        for (int f = 2; f <= 3; f++)
        begin
            loadSensorData();           // New values before the next frame starts
            waitSampleValid();
            checkSample(f);
        end
        assert (!busError) else reportFailure("busError set with all ACKs");

        // Second run with the gyroscope NACKing
        applyReset(1'b1);
        do
        begin
            @(negedge CLOCK_50);
            assert (!sampleValid) else reportFailure("sample published with a NACK");
        end
        while (!busError);
        repeat (2 * frameCycles) @(negedge CLOCK_50)
            assert (busError && !sampleValid)
            else reportFailure("busError dropped or a sample was published");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- sources.f
+incdir+verilog
verilog/imuPkg.sv
verilog/i2cBitTimer.sv
verilog/i2cMaster.sv
verilog/imuSequencer.sv
verilog/imuInterface.sv
tb/i2cSensorModel.sv
tb/imuInterfaceTb.sv

//--- Makefile
# Verilator build and run for the IMU interface testbench

VERILATOR ?= verilator
TOP       ?= imuInterfaceTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
